// File: Bender.yml
package:
  name: ldpc_dec_engine

sources:
  - include_dirs:
      - .
    files:
      - ldpc_dec_pkg.sv
      - ldpc_dec_ibuffer.sv
      - ldpc_dec_ctrl.sv
      - ldpc_dec_vnode.sv
      - ldpc_dec_cnode.sv
      - ldpc_dec_sink.sv
      - ldpc_dec_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - ldpc_dec_checker.sv
      - tb_ldpc_dec_engine.sv

// File: compile.f
+incdir+.
ldpc_dec_pkg.sv
ldpc_dec_ibuffer.sv
ldpc_dec_ctrl.sv
ldpc_dec_vnode.sv
ldpc_dec_cnode.sv
ldpc_dec_sink.sv
ldpc_dec_engine.sv
ldpc_dec_checker.sv
tb_ldpc_dec_engine.sv

// File: ldpc_dec_checker.sv
//----------------------------------------------------------------------
// output checker of the decoder testbench: queues expected frames
// and compares every output word, one line per finished test
//----------------------------------------------------------------------
module ldpc_dec_checker (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 obusy,
  input  logic                 osop,
  input  logic                 oeop,
  input  logic                 oval,
  input  logic                 odat,
  input  logic                 odecfail,
  input  ldpc_dec_pkg::addr_t  oaddr,
  input  ldpc_dec_pkg::tag_t   otag,
  input  ldpc_dec_pkg::err_t   oerr,
  input  logic                 idle_chk,
  input  logic                 exp_push,
  input  int                   exp_test,
  input  logic [ldpc_dec_pkg::N_BITS-1:0] exp_bits,
  input  logic                 exp_fail,
  input  ldpc_dec_pkg::err_t   exp_err,
  input  ldpc_dec_pkg::tag_t   exp_tag,
  input  logic                 report,
  output int                   n_frames,
  output int                   n_errors
);

  import ldpc_dec_pkg::*;

  // expected frames, oldest at [0]
  logic [N_BITS-1:0]  bits_q [$];
  logic               fail_q [$];
  err_t               err_q  [$];
  tag_t               tag_q  [$];
  int                 test_q [$];

  int    idx       = 0;  // word position in the current frame
  int    test_errs = 0;
  int    n_tests   = 0;
  int    n_failed  = 0;
  logic  idle_d    = 1'b0;

  initial begin
    n_frames = 0;
    n_errors = 0;
  end

  task automatic flag_mismatch(input string msg);
    $display("mismatch %0t: %s", $time, msg);
    n_errors++;
    test_errs++;
  endtask

  task automatic flag_fault(input string msg);
    $display("%s (time %0t)", msg, $time);
    n_errors++;
    test_errs++;
  endtask

  task automatic close_test(input string name);
    if (test_errs == 0) $display("%s: ok", name);
    else $display("%s: failed with %0d errors", name, test_errs);
    n_tests++;
    if (test_errs != 0) n_failed++;
    test_errs = 0;
  endtask

  //--------------------------------------------------------------------
  // compare on the rising edge, values are from the settled cycle
  //--------------------------------------------------------------------
  always @(posedge iclk) begin
    if (!ireset) begin
      if (exp_push) begin
        bits_q.push_back(exp_bits);
        fail_q.push_back(exp_fail);
        err_q.push_back(exp_err);
        tag_q.push_back(exp_tag);
        test_q.push_back(exp_test);
      end
      if (idle_chk && (obusy || oval || osop || oeop)) begin
        flag_mismatch($sformatf("idle after reset, obusy %b oval %b osop %b oeop %b",
                                obusy, oval, osop, oeop));
      end
      if (idle_d && !idle_chk) close_test("test 6 idle after reset");
      idle_d <= idle_chk;

      if (oval && bits_q.size() == 0) begin
        flag_fault("output word came out while no frame was expected");
      end
      else if (oval) begin
        if (oaddr !== addr_t'(idx)) flag_mismatch($sformatf("oaddr %0d, want %0d", oaddr, idx));
        if (osop !== (idx == 0)) flag_mismatch($sformatf("osop %b at word %0d", osop, idx));
        if (oeop !== (idx == N_BITS-1)) flag_mismatch($sformatf("oeop %b at word %0d", oeop, idx));
        if (odat !== bits_q[0][idx]) begin
          flag_mismatch($sformatf("bit %0d is %b, want %b", idx, odat, bits_q[0][idx]));
        end
        if (idx == N_BITS-1) begin  // side fields ride on eop
          if (otag !== tag_q[0]) flag_mismatch($sformatf("otag %h, want %h", otag, tag_q[0]));
          if (odecfail !== fail_q[0]) begin
            flag_mismatch($sformatf("odecfail %b, want %b", odecfail, fail_q[0]));
          end
          if (oerr !== err_q[0]) flag_mismatch($sformatf("oerr %0d, want %0d", oerr, err_q[0]));
          close_test($sformatf("test %0d frame %0d tag %h", test_q[0], n_frames, tag_q[0]));
          void'(bits_q.pop_front());
          void'(fail_q.pop_front());
          void'(err_q.pop_front());
          void'(tag_q.pop_front());
          void'(test_q.pop_front());
          n_frames++;
          idx = 0;
        end
        else begin
          idx++;
        end
      end
      else begin
        if (osop || oeop) flag_fault("osop or oeop was high without oval");
        if (idx != 0) begin
          flag_fault("output frame stopped before its last word");
          idx = 0;
        end
      end
    end
  end

  always @(posedge report) begin
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             n_tests, n_tests - n_failed, n_failed, n_errors);
  end

endmodule

// File: ldpc_dec_cnode.sv
//----------------------------------------------------------------------
// horizontal step: check-to-variable messages by plain min-sum
// cleared on init_stb, recomputed on cnode_stb
//----------------------------------------------------------------------
module ldpc_dec_cnode (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 init_stb,
  input  logic                 cnode_stb,
  input  ldpc_dec_pkg::node_t  v2c [ldpc_dec_pkg::M_CHECKS][ldpc_dec_pkg::N_BITS],
  output ldpc_dec_pkg::node_t  c2v [ldpc_dec_pkg::M_CHECKS][ldpc_dec_pkg::N_BITS]
);

  import ldpc_dec_pkg::*;

  node_t  c2v_nxt [M_CHECKS][N_BITS];

  // |x|, fine since messages never reach -32
  function automatic mag_t node_mag(input node_t x);
    node_t ax;
    ax = (x < 0) ? -x : x;
    return mag_t'(ax);
  endfunction

  //--------------------------------------------------------------------
  // min-sum, every edge looks at the other bits of its check
  //--------------------------------------------------------------------
  always_comb begin
    mag_t  mn;
    logic  sgn;
    node_t res;
    for (int m = 0; m < M_CHECKS; m++) begin
      for (int v = 0; v < N_BITS; v++) begin
        mn  = '1;    // 31, top of the range
        sgn = 1'b0;
        for (int u = 0; u < N_BITS; u++) begin
          if (h_tab[m][u] && (u != v)) begin  // skip self
            if (node_mag(v2c[m][u]) < mn) begin
              mn = node_mag(v2c[m][u]);
            end
            sgn = sgn ^ (v2c[m][u] < 0);   // zero counts positive
          end
        end
        res = node_t'({1'b0, mn});
        if (!h_tab[m][v]) begin
          c2v_nxt[m][v] = '0;            // no edge
        end
        else begin
          c2v_nxt[m][v] = sgn ? -res : res;
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // message registers
  //--------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      for (int m = 0; m < M_CHECKS; m++) begin
        for (int v = 0; v < N_BITS; v++) begin
          c2v[m][v] <= '0;
        end
      end
    end
    else if (init_stb) begin
      for (int m = 0; m < M_CHECKS; m++) begin
        for (int v = 0; v < N_BITS; v++) begin
          c2v[m][v] <= '0;  // first vertical step sees llr only
        end
      end
    end
    else if (cnode_stb) begin
      c2v <= c2v_nxt;
    end
  end

endmodule

// File: ldpc_dec_ctrl.sv
//----------------------------------------------------------------------
// frame controller: init, then niter pairs of horizontal and
// vertical steps, then one output request; busy covers all of it
//----------------------------------------------------------------------
module ldpc_dec_ctrl (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  frame_done,
  input  logic                  out_done,
  input  ldpc_dec_pkg::niter_t  niter,
  output logic                  busy,
  output logic                  init_stb,
  output logic                  cnode_stb,
  output logic                  vnode_stb,
  output logic                  out_stb
);

  import ldpc_dec_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_INIT,
    ST_HOR,   // cnode step
    ST_VER,   // vnode step
    ST_OUT    // sink streaming
  } state_t;

  state_t  state;
  niter_t  iter_cnt;   // finished iterations
  logic    last_iter;

  assign last_iter = (iter_cnt == niter_t'(niter - 1'b1));

  // frame_done counts too, so the word right after eop is already refused
  assign busy = (state != ST_IDLE) | frame_done;

  //--------------------------------------------------------------------
  // fsm, strobes are one cycle pulses issued on state entry
  //--------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= ST_IDLE;
      iter_cnt  <= '0;
      init_stb  <= 1'b0;
      cnode_stb <= 1'b0;
      vnode_stb <= 1'b0;
      out_stb   <= 1'b0;
    end
    else begin
      init_stb  <= 1'b0;
      cnode_stb <= 1'b0;
      vnode_stb <= 1'b0;
      out_stb   <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (frame_done) begin
            state    <= ST_INIT;
            init_stb <= 1'b1;
          end
        end
        ST_INIT: begin  // messages load this cycle
          iter_cnt <= '0;
          if (niter == '0) begin  // plain llr signs out
            state   <= ST_OUT;
            out_stb <= 1'b1;
          end
          else begin
            state     <= ST_HOR;
            cnode_stb <= 1'b1;
          end
        end
        ST_HOR: begin
          state     <= ST_VER;
          vnode_stb <= 1'b1;
        end
        ST_VER: begin
          iter_cnt <= iter_cnt + 1'b1;
          if (last_iter) begin
            state   <= ST_OUT;
            out_stb <= 1'b1;
          end
          else begin
            state     <= ST_HOR;
            cnode_stb <= 1'b1;
          end
        end
        ST_OUT: begin
          if (out_done) begin  // sink on its eop word
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: ldpc_dec_engine.sv
//----------------------------------------------------------------------
// top of the flooding min-sum decoder, 8 bit / 4 check code
// llr stream in, hard decisions with fail flag and flip count out
//----------------------------------------------------------------------
module ldpc_dec_engine (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  isop,
  input  logic                  ieop,
  input  logic                  ival,
  input  ldpc_dec_pkg::tag_t    itag,
  input  ldpc_dec_pkg::niter_t  initer,
  input  ldpc_dec_pkg::llr_t    illr,
  output logic                  obusy,
  output logic                  osop,
  output logic                  oeop,
  output logic                  oval,
  output logic                  odecfail,
  output ldpc_dec_pkg::addr_t   oaddr,
  output ldpc_dec_pkg::tag_t    otag,
  output logic                  odat,
  output ldpc_dec_pkg::err_t    oerr
);

  import ldpc_dec_pkg::*;

  //--------------------------------------------------------------------
  // internal wiring
  //--------------------------------------------------------------------
  llr_t               llr_buf [N_BITS];
  niter_t             niter;
  tag_t               tag;
  logic               frame_done;
  logic               busy;
  logic               init_stb;
  logic               cnode_stb;
  logic               vnode_stb;
  logic               out_stb;
  logic               out_done;
  node_t              v2c [M_CHECKS][N_BITS];
  node_t              c2v [M_CHECKS][N_BITS];
  logic [N_BITS-1:0]  hard;

  assign obusy = busy;

  ldpc_dec_ibuffer ibuf (
    .iclk, .ireset, .isop, .ieop, .ival, .busy,
    .itag, .initer, .illr,
    .llr_buf, .niter, .tag, .frame_done
  );

  ldpc_dec_ctrl ctrl (
    .iclk, .ireset, .frame_done, .out_done, .niter,
    .busy, .init_stb, .cnode_stb, .vnode_stb, .out_stb
  );

  // vertical step
  ldpc_dec_vnode vnode (
    .iclk, .ireset, .init_stb, .vnode_stb,
    .llr_buf, .c2v, .v2c, .hard
  );

  // horizontal step
  ldpc_dec_cnode cnode (
    .iclk, .ireset, .init_stb, .cnode_stb,
    .v2c, .c2v
  );

  ldpc_dec_sink sink (
    .iclk, .ireset, .out_stb, .hard, .llr_buf, .tag,
    .osop, .oeop, .oval, .odat, .odecfail, .out_done,
    .oaddr, .otag, .oerr
  );

endmodule

// File: ldpc_dec_ibuffer.sv
//----------------------------------------------------------------------
// input buffer: writes the llr stream into a register store and
// latches iteration count and tag with the first word of a frame
//----------------------------------------------------------------------
module ldpc_dec_ibuffer (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  isop,
  input  logic                  ieop,
  input  logic                  ival,
  input  logic                  busy,
  input  ldpc_dec_pkg::tag_t    itag,
  input  ldpc_dec_pkg::niter_t  initer,
  input  ldpc_dec_pkg::llr_t    illr,
  output ldpc_dec_pkg::llr_t    llr_buf [ldpc_dec_pkg::N_BITS],
  output ldpc_dec_pkg::niter_t  niter,
  output ldpc_dec_pkg::tag_t    tag,
  output logic                  frame_done
);

  import ldpc_dec_pkg::*;

  logic   take;   // word accepted this cycle
  addr_t  wcnt;   // next write address
  addr_t  waddr;

  assign take  = ival & ~busy;       // anything while busy is dropped
  assign waddr = isop ? '0 : wcnt;   // sop restarts the frame at 0

  // write counter and frame end strobe
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wcnt       <= '0;
      frame_done <= 1'b0;
    end
    else begin
      frame_done <= take & ieop;  // one cycle pulse
      if (take) begin
        wcnt <= waddr + 1'b1;
      end
    end
  end

  // llr store plus niter/tag latch
  always_ff @(posedge iclk) begin
    if (take) begin
      llr_buf[waddr] <= illr;
      if (isop) begin
        niter <= initer;
        tag   <= itag;
      end
    end
  end

endmodule

// File: ldpc_dec_params.svh
//----------------------------------------------------------------------
// code size and field widths of the LDPC decoder engine
// pulled in by the package and the testbench
//----------------------------------------------------------------------
`ifndef LDPC_DEC_PARAMS_SVH
`define LDPC_DEC_PARAMS_SVH

// code geometry
`define LDPC_N   8  // code bits
`define LDPC_M   4  // parity checks

// datapath widths
`define LLR_W    5  // input llr
`define NODE_W   6  // message, holds -31..31
`define TOT_W    8  // bit total, llr plus two messages

// side fields
`define TAG_W    4
`define NITER_W  8
`define ERR_W    4  // up to 8 flipped bits
`define ADDR_W   3  // bit address 0..7

`endif

// File: ldpc_dec_pkg.sv
//----------------------------------------------------------------------
// value types, parity-check table and saturation for the decoder
// modules import this inside their body
//----------------------------------------------------------------------
`include "ldpc_dec_params.svh"

package ldpc_dec_pkg;

  localparam int N_BITS   = `LDPC_N;
  localparam int M_CHECKS = `LDPC_M;

  localparam int NODE_MAX = 2**(`NODE_W-1) - 1;  // 31, symmetric clamp

  //--------------------------------------------------------------------
  // value types
  //--------------------------------------------------------------------
  typedef logic signed [`LLR_W-1:0]   llr_t;
  typedef logic signed [`NODE_W-1:0]  node_t;
  typedef logic signed [`TOT_W-1:0]   total_t;
  typedef logic [`NODE_W-2:0]         mag_t;    // message magnitude
  typedef logic [`TAG_W-1:0]          tag_t;
  typedef logic [`NITER_W-1:0]        niter_t;
  typedef logic [`ADDR_W-1:0]         addr_t;
  typedef logic [`ERR_W-1:0]          err_t;
  typedef logic [`LDPC_N-1:0]         hrow_t;   // one check row, bit v at [v]

  //--------------------------------------------------------------------
  // parity-check matrix
  //--------------------------------------------------------------------
  localparam hrow_t h_tab [M_CHECKS] = '{
    8'h1b,  // check 0 : bits 0 1 3 4
    8'h36,  // check 1 : bits 1 2 4 5
    8'h65,  // check 2 : bits 0 2 5 6
    8'hc8   // check 3 : bits 3 6 7
  };

  // clamp a total into the message range
  function automatic node_t sat_node(input total_t x);
    node_t res;
    if (x > total_t'(NODE_MAX)) begin
      res = node_t'(NODE_MAX);
    end
    else if (x < -total_t'(NODE_MAX)) begin
      res = -node_t'(NODE_MAX);
    end
    else begin
      res = node_t'(x);  // in range, plain truncation
    end
    return res;
  endfunction

endpackage

// File: ldpc_dec_sink.sv
//----------------------------------------------------------------------
// output sink: latches the decisions, streams them one bit per cycle,
// counts flips against the llr signs and flags a nonzero syndrome
//----------------------------------------------------------------------
module ldpc_dec_sink (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 out_stb,
  input  logic [ldpc_dec_pkg::N_BITS-1:0] hard,
  input  ldpc_dec_pkg::llr_t   llr_buf [ldpc_dec_pkg::N_BITS],
  input  ldpc_dec_pkg::tag_t   tag,
  output logic                 osop,
  output logic                 oeop,
  output logic                 oval,
  output logic                 odat,
  output logic                 odecfail,
  output logic                 out_done,
  output ldpc_dec_pkg::addr_t  oaddr,
  output ldpc_dec_pkg::tag_t   otag,
  output ldpc_dec_pkg::err_t   oerr
);

  import ldpc_dec_pkg::*;

  logic [N_BITS-1:0]  hard_r;   // latched decisions
  logic [N_BITS-1:0]  sign_r;   // latched llr signs
  logic               active;
  addr_t              cnt;
  err_t               err_acc;  // flips before the current bit
  logic               decfail;
  logic               flip;

  // syndrome of the incoming decisions
  always_comb begin
    decfail = 1'b0;
    for (int m = 0; m < M_CHECKS; m++) begin
      decfail = decfail | (^(h_tab[m] & hard));
    end
  end

  //--------------------------------------------------------------------
  // latch and stream
  //--------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      active   <= 1'b0;
      cnt      <= '0;
      err_acc  <= '0;
      odecfail <= 1'b0;
    end
    else if (out_stb) begin
      active   <= 1'b1;
      cnt      <= '0;
      err_acc  <= '0;
      odecfail <= decfail;
    end
    else if (active) begin
      cnt     <= cnt + 1'b1;
      err_acc <= oerr;
      if (oeop) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (out_stb) begin
      hard_r <= hard;
      otag   <= tag;
      for (int v = 0; v < N_BITS; v++) begin
        sign_r[v] <= (llr_buf[v] < 0);
      end
    end
  end

  assign flip     = hard_r[cnt] ^ sign_r[cnt];
  assign oval     = active;
  assign osop     = active & (cnt == '0);
  assign oeop     = active & (cnt == addr_t'(N_BITS-1));
  assign oaddr    = cnt;
  assign odat     = hard_r[cnt];
  assign oerr     = err_acc + err_t'(flip);  // full count on eop
  assign out_done = oeop;                    // frees the controller

endmodule

// File: ldpc_dec_vnode.sv
//----------------------------------------------------------------------
// vertical step: bit totals, variable-to-check messages and the
// hard decisions; loads on init_stb, updates on vnode_stb
//----------------------------------------------------------------------
module ldpc_dec_vnode (
  input  logic                 iclk,
  input  logic                 ireset,
  input  logic                 init_stb,
  input  logic                 vnode_stb,
  input  ldpc_dec_pkg::llr_t   llr_buf [ldpc_dec_pkg::N_BITS],
  input  ldpc_dec_pkg::node_t  c2v [ldpc_dec_pkg::M_CHECKS][ldpc_dec_pkg::N_BITS],
  output ldpc_dec_pkg::node_t  v2c [ldpc_dec_pkg::M_CHECKS][ldpc_dec_pkg::N_BITS],
  output logic [ldpc_dec_pkg::N_BITS-1:0] hard
);

  import ldpc_dec_pkg::*;

  total_t  total [N_BITS];  // registered totals
  total_t  sum   [N_BITS];  // llr + incoming check messages

  //--------------------------------------------------------------------
  // bit sums over the checks each bit sits in
  //--------------------------------------------------------------------
  always_comb begin
    total_t acc;
    for (int v = 0; v < N_BITS; v++) begin
      acc = total_t'(llr_buf[v]);  // sign extended
      for (int m = 0; m < M_CHECKS; m++) begin
        if (h_tab[m][v]) begin
          acc = acc + total_t'(c2v[m][v]);
        end
      end
      sum[v] = acc;
    end
  end

  //--------------------------------------------------------------------
  // totals and outgoing messages, non edges kept at 0
  //--------------------------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      for (int v = 0; v < N_BITS; v++) begin
        total[v] <= '0;
        for (int m = 0; m < M_CHECKS; m++) begin
          v2c[m][v] <= '0;
        end
      end
    end
    else if (init_stb) begin
      for (int v = 0; v < N_BITS; v++) begin
        total[v] <= total_t'(llr_buf[v]);
        for (int m = 0; m < M_CHECKS; m++) begin
          v2c[m][v] <= h_tab[m][v] ? sat_node(total_t'(llr_buf[v])) : '0;
        end
      end
    end
    else if (vnode_stb) begin
      for (int v = 0; v < N_BITS; v++) begin
        total[v] <= sum[v];
        for (int m = 0; m < M_CHECKS; m++) begin
          // extrinsic: drop what check m told us
          v2c[m][v] <= h_tab[m][v] ? sat_node(sum[v] - total_t'(c2v[m][v])) : '0;
        end
      end
    end
  end

  // hard decision is the total sign, zero reads as 0
  always_comb begin
    for (int v = 0; v < N_BITS; v++) begin
      hard[v] = (total[v] < 0);
    end
  end

endmodule

// File: tb_ldpc_dec_engine.sv
//----------------------------------------------------------------------
// testbench for the LDPC decoder engine with clock, reset, frames
// and the reference model, the checker beside the dut compares
//----------------------------------------------------------------------
`include "ldpc_dec_params.svh"

module tb_ldpc_dec_engine;

  import ldpc_dec_pkg::*;

  localparam int N_FRAMES  = 25;  // 1 + 1 + 2 + 20 + 1
  localparam int MAX_NITER = 6;
  localparam int LIMIT_CYC = N_FRAMES * (10 + 2*MAX_NITER + 8 + 4) * 2;
  localparam int FRAME_W   = `LDPC_N * `LLR_W;

  logic    iclk, ireset;
  logic    isop, ieop, ival;
  tag_t    itag;
  niter_t  initer;
  llr_t    illr;
  logic    obusy, osop, oeop, oval, odecfail, odat;
  addr_t   oaddr;
  tag_t    otag;
  err_t    oerr;

  // expected frame handoff to the checker
  logic               exp_push, exp_fail, idle_chk, report;
  int                 exp_test;
  logic [`LDPC_N-1:0] exp_bits;
  err_t               exp_err;
  tag_t               exp_tag;
  int                 n_frames, n_errors;

  integer  seed = 32'h5a8e;
  int      cyc  = 0;

  ldpc_dec_engine dut (
    .iclk, .ireset, .isop, .ieop, .ival, .itag, .initer, .illr,
    .obusy, .osop, .oeop, .oval, .odecfail, .oaddr, .otag, .odat, .oerr
  );

  ldpc_dec_checker chk (
    .iclk, .ireset, .obusy, .osop, .oeop, .oval, .odat, .odecfail,
    .oaddr, .otag, .oerr, .idle_chk, .exp_push, .exp_test, .exp_bits,
    .exp_fail, .exp_err, .exp_tag, .report, .n_frames, .n_errors
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;
  end

  // run limit from frame count and longest decode
  always @(posedge iclk) begin
    cyc++;
    if (cyc >= LIMIT_CYC) begin
      $display("timeout: only %0d of %0d frames came out within %0d cycles",
               n_frames, N_FRAMES, LIMIT_CYC);
      $display("Verification failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------
  // reference model of flooding min-sum without scaling
  //--------------------------------------------------------------------
  function automatic int clamp31(input int x);
    return (x > 31) ? 31 : ((x < -31) ? -31 : x);
  endfunction

  // true when bit v sits in check m
  function automatic bit in_check(input int m, input int v);
    case (m)
      0: return (v == 0) || (v == 1) || (v == 3) || (v == 4);
      1: return (v == 1) || (v == 2) || (v == 4) || (v == 5);
      2: return (v == 0) || (v == 2) || (v == 5) || (v == 6);
      3: return (v == 3) || (v == 6) || (v == 7);
      default: return 1'b0;
    endcase
  endfunction

  function automatic void ldpc_ref(input logic [FRAME_W-1:0] llrs, input int niter,
                                   output logic [`LDPC_N-1:0] bits,
                                   output logic fail, output err_t err);
    int lv [`LDPC_N];
    int tot [`LDPC_N];
    int v2c [`LDPC_M*`LDPC_N];  // index m*N + v
    int c2v [`LDPC_M*`LDPC_N];
    int mn, mag, sg, s, nerr;
    logic par;
    for (int v = 0; v < `LDPC_N; v++) begin
      lv[v]  = $signed(llrs[v*`LLR_W +: `LLR_W]);
      tot[v] = lv[v];
      for (int m = 0; m < `LDPC_M; m++) begin
        v2c[m*`LDPC_N+v] = in_check(m, v) ? clamp31(lv[v]) : 0;
        c2v[m*`LDPC_N+v] = 0;
      end
    end
    for (int it = 0; it < niter; it++) begin
      // horizontal step takes min magnitude and sign xor over the other bits
      for (int m = 0; m < `LDPC_M; m++) begin
        for (int v = 0; v < `LDPC_N; v++) begin
          mn = 31;
          sg = 0;
          for (int u = 0; u < `LDPC_N; u++) begin
            if (in_check(m, u) && u != v) begin
              mag = (v2c[m*`LDPC_N+u] < 0) ? -v2c[m*`LDPC_N+u] : v2c[m*`LDPC_N+u];
              if (mag < mn) mn = mag;
              if (v2c[m*`LDPC_N+u] < 0) sg = sg ^ 1;
            end
          end
          c2v[m*`LDPC_N+v] = in_check(m, v) ? (sg ? -mn : mn) : 0;
        end
      end
      // vertical step forms totals and then extrinsic messages
      for (int v = 0; v < `LDPC_N; v++) begin
        s = lv[v];
        for (int m = 0; m < `LDPC_M; m++) begin
          if (in_check(m, v)) s = s + c2v[m*`LDPC_N+v];
        end
        tot[v] = s;
        for (int m = 0; m < `LDPC_M; m++) begin
          v2c[m*`LDPC_N+v] = in_check(m, v) ? clamp31(s - c2v[m*`LDPC_N+v]) : 0;
        end
      end
    end
    nerr = 0;
    for (int v = 0; v < `LDPC_N; v++) begin
      bits[v] = (tot[v] < 0);
      if (bits[v] != (lv[v] < 0)) nerr++;
    end
    fail = 1'b0;
    for (int m = 0; m < `LDPC_M; m++) begin
      par = 1'b0;
      for (int v = 0; v < `LDPC_N; v++) begin
        if (in_check(m, v)) par = par ^ bits[v];
      end
      fail = fail | par;  // any odd check
    end
    err = err_t'(nerr);
  endfunction

  //--------------------------------------------------------------------
  // stimulus helpers run from a falling edge
  //--------------------------------------------------------------------
  function automatic logic [FRAME_W-1:0] random_frame();
    logic [FRAME_W-1:0] f;
    for (int v = 0; v < `LDPC_N; v++) begin
      f[v*`LLR_W +: `LLR_W] = $random(seed);
    end
    return f;
  endfunction

  task automatic send_frame(input int test_id, input tag_t tag, input niter_t niter,
                            input logic [FRAME_W-1:0] llrs);
    logic [`LDPC_N-1:0] bits;
    logic               fail;
    err_t               err;
    ldpc_ref(llrs, niter, bits, fail, err);
    while (obusy) @(negedge iclk);  // wait for idle since there is no back-pressure
    for (int k = 0; k < `LDPC_N; k++) begin
      isop     = (k == 0);
      ieop     = (k == `LDPC_N-1);
      ival     = 1'b1;
      itag     = tag;
      initer   = niter;
      illr     = llrs[k*`LLR_W +: `LLR_W];
      exp_push = (k == 0);  // expected frame goes along with sop
      exp_test = test_id;
      exp_bits = bits;
      exp_fail = fail;
      exp_err  = err;
      exp_tag  = tag;
      @(negedge iclk);
    end
    isop     = 1'b0;
    ieop     = 1'b0;
    ival     = 1'b0;
    exp_push = 1'b0;
  endtask

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------
  initial begin
    ireset   = 1'b1;
    isop     = 1'b0;
    ieop     = 1'b0;
    ival     = 1'b0;
    itag     = '0;
    initer   = '0;
    illr     = '0;
    exp_push = 1'b0;
    exp_test = 0;
    exp_bits = '0;
    exp_fail = 1'b0;
    exp_err  = '0;
    exp_tag  = '0;
    idle_chk = 1'b0;
    report   = 1'b0;
    repeat (10) @(negedge iclk);
    ireset = 1'b0;

    idle_chk = 1'b1;  // quiet outputs before any input
    repeat (8) @(negedge iclk);
    idle_chk = 1'b0;

    send_frame(1, 4'h1, 8'd4, {8{5'h0f}});  // strong +15 everywhere
    // codeword with bits 0..2 set and a weak wrong -2 on bit 5
    send_frame(2, 4'h2, 8'd3, {5'h0c, 5'h0c, 5'h1e, 5'h0c, 5'h0c, 5'h14, 5'h14, 5'h14});
    send_frame(3, 4'h3, 8'd0, random_frame());
    send_frame(3, 4'h4, 8'd0, random_frame());
    for (int i = 0; i < 20; i++) begin
      send_frame(4, tag_t'($random(seed)), niter_t'({$random(seed)} % 7), random_frame());
    end

    // words during busy must be dropped
    send_frame(5, 4'h5, 8'd4, random_frame());
    for (int j = 0; j < 5; j++) begin
      ival   = 1'b1;
      isop   = (j == 0);
      ieop   = (j == 4);
      itag   = 4'hf;
      initer = 8'd7;
      illr   = $random(seed);
      @(negedge iclk);
    end
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;

    while (n_frames < N_FRAMES) @(negedge iclk);
    repeat (10) @(negedge iclk);  // room for stray output
    report = 1'b1;
    @(negedge iclk);
    if (n_errors == 0) begin
      $display("Verification passed");
    end
    else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
